/* all.f */
rtl/busPkg.sv
rtl/lineBuffer.sv
rtl/busFsm.sv
rtl/busDp.sv
rtl/busTop.sv
verification/busTb.sv

/* rtl/busDp.sv */
// Bus data path; cache line addresses must be line aligned since beat offsets add with no wrap
`timescale 1ns/10ps
`default_nettype none

module busDp #(
  parameter int xLen,
  parameter int paBits,
  parameter int wordsPerLine,
  parameter int lineLen,
  parameter int logWpl,
  parameter int cacheEnabled
) (
  input  logic                clk,
  input  logic                arstN,
  // Cache side
  input  logic [paBits-1:0]   cacheBusAdr,
  input  logic                cacheFetchLine,
  input  logic                cacheWriteLine,
  output logic                cacheBusAck,
  output logic [lineLen-1:0]  lineData,
  // LSU side
  input  logic [paBits-1:0]   lsuPAdr,
  input  busPkg::memRwE       lsuRw,
  input  logic [2:0]          lsuFunct3,
  input  logic                cacheable,
  input  logic                ignoreRequest,
  input  logic                cpuBusy,
  output logic                busStall,
  output logic                busCommitted,
  output logic                selUncachedAdr,
  output logic                selLsuBusWord,
  // Bus side
  input  logic [xLen-1:0]     hrData,
  input  logic                busAck,
  input  logic                busInit,
  output logic [paBits-1:0]   hAddr,
  output logic [2:0]          hSize,
  output logic [2:0]          hBurst,
  output logic [1:0]          hTrans,
  output logic                busRead,
  output logic                busWrite,
  output logic                busTransComplete,
  output logic [logWpl-1:0]   wordCount
);

  // Without a cache every transfer is a single beat
  localparam int wordCountThreshold = (cacheEnabled != 0) ? wordsPerLine - 1 : 0;
  // Byte offset of one word
  localparam int byteShift = $clog2(xLen / 8);
  // Full word AHB size
  localparam logic [2:0] wordSize = (xLen == 32) ? 3'b010 : 3'b011;

  logic [paBits-1:0] baseAddr;
  logic [paBits-1:0] beatOffset;
  logic [logWpl-1:0] wordCountDelayed;
  logic              bufferCaptureEn;

  //////////////////////////////////////////////////
  // Address and size
  //////////////////////////////////////////////////

  // LSU address for uncached singles, cache line base otherwise
  assign baseAddr   = selUncachedAdr ? lsuPAdr : cacheBusAdr;
  assign beatOffset = paBits'(wordCount) << byteShift;
  assign hAddr      = baseAddr + beatOffset;

  // Uncached access size comes from the load/store funct3
  assign hSize = selUncachedAdr ? lsuFunct3 : wordSize;

  //////////////////////////////////////////////////
  // Controller and fetch buffer
  //////////////////////////////////////////////////

  busFsm #(
    .wordCountThreshold (wordCountThreshold),
    .logWpl             (logWpl),
    .cacheEnabled       (cacheEnabled)
  ) fsm (
    .clk, .arstN, .ignoreRequest, .lsuRw, .cacheFetchLine, .cacheWriteLine,
    .busAck, .busInit, .cpuBusy, .cacheable,
    .busStall, .busWrite, .busRead, .selLsuBusWord, .bufferCaptureEn,
    .hBurst, .hTrans, .busTransComplete, .cacheBusAck, .busCommitted,
    .selUncachedAdr, .wordCount, .wordCountDelayed
  );

  // Registers each returned beat into its line slot
  lineBuffer #(
    .xLen         (xLen),
    .wordsPerLine (wordsPerLine)
  ) fetchBuf (
    .clk, .arstN, .hrData, .bufferCaptureEn, .wordCountDelayed, .lineData
  );

endmodule

`default_nettype wire

/* rtl/busFsm.sv */
// Bus controller FSM; one transfer at a time, LSU and cache requests must hold until acknowledged
`timescale 1ns/10ps
`default_nettype none

module busFsm #(
  parameter int wordCountThreshold,
  parameter int logWpl,
  parameter int cacheEnabled
) (
  input  logic                clk,
  input  logic                arstN,
  // Requests from the LSU and the cache
  input  logic                ignoreRequest,
  input  busPkg::memRwE       lsuRw,
  input  logic                cacheFetchLine,
  input  logic                cacheWriteLine,
  // Bus response
  input  logic                busAck,
  input  logic                busInit,
  // CPU side
  input  logic                cpuBusy,
  input  logic                cacheable,
  // Controls
  output logic                busStall,
  output logic                busWrite,
  output logic                busRead,
  output logic                selLsuBusWord,
  output logic                bufferCaptureEn,
  output busPkg::hBurstE      hBurst,
  output busPkg::hTransE      hTrans,
  output logic                busTransComplete,
  output logic                cacheBusAck,
  output logic                busCommitted,
  output logic                selUncachedAdr,
  output logic [logWpl-1:0]   wordCount,
  output logic [logWpl-1:0]   wordCountDelayed
);

  // Burst code that covers one whole line
  localparam busPkg::hBurstE lineBurst = (logWpl == 4) ? busPkg::incr16 :
                                         (logWpl == 3) ? busPkg::incr8  : busPkg::incr4;

  busPkg::busStateE state;
  busPkg::busStateE stateNext;

  logic uncachedReq;
  logic uncachedWriteReq;
  logic lineFetchReq;
  logic lineWriteReq;
  logic anyReq;
  logic lineState;
  logic uncachedState;
  logic doneState;
  logic lastBeat;

  //////////////////////////////////////////////////
  // Request decode
  //////////////////////////////////////////////////

  // Uncached access only when the LSU asks and the page is not cacheable
  assign uncachedReq      = (lsuRw != busPkg::rwNone) && !cacheable && !ignoreRequest;
  // Anything but a plain write is sequenced as a read
  assign uncachedWriteReq = uncachedReq && (lsuRw == busPkg::rwWrite);
  // Line traffic exists only with a cache built in
  assign lineFetchReq     = (cacheEnabled != 0) && cacheFetchLine;
  assign lineWriteReq     = (cacheEnabled != 0) && cacheWriteLine;
  assign anyReq           = uncachedReq || lineFetchReq || lineWriteReq;

  // State groups
  assign lineState     = (state == busPkg::stLineFetch) || (state == busPkg::stLineWrite);
  assign uncachedState = (state == busPkg::stUncachedRead) || (state == busPkg::stUncachedWrite);
  assign doneState     = (state == busPkg::stUncachedReadDone) ||
                         (state == busPkg::stUncachedWriteDone) ||
                         (state == busPkg::stLineDone);

  // Final beat of a line
  assign lastBeat = (wordCount == logWpl'(wordCountThreshold));

  //////////////////////////////////////////////////
  // State sequencing
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      state <= busPkg::stReady;
    end else begin
      state <= stateNext;
    end
  end

  always_comb begin
    stateNext = state;
    case (state)
      busPkg::stReady: begin
        // Uncached first, then write back before refill
        if (uncachedWriteReq) begin
          stateNext = busPkg::stUncachedWrite;
        end else if (uncachedReq) begin
          stateNext = busPkg::stUncachedRead;
        end else if (lineWriteReq) begin
          stateNext = busPkg::stLineWrite;
        end else if (lineFetchReq) begin
          stateNext = busPkg::stLineFetch;
        end
      end
      // Singles finish on their one acknowledge
      busPkg::stUncachedRead: begin
        if (busAck) begin
          stateNext = busPkg::stUncachedReadDone;
        end
      end
      busPkg::stUncachedWrite: begin
        if (busAck) begin
          stateNext = busPkg::stUncachedWriteDone;
        end
      end
      // Bursts finish on the acknowledge of the last beat
      busPkg::stLineFetch, busPkg::stLineWrite: begin
        if (busAck && lastBeat) begin
          stateNext = busPkg::stLineDone;
        end
      end
      // Done states wait for the CPU to take the result
      busPkg::stUncachedReadDone, busPkg::stUncachedWriteDone, busPkg::stLineDone: begin
        if (!cpuBusy) begin
          stateNext = busPkg::stReady;
        end
      end
      default: stateNext = busPkg::stReady;
    endcase
  end

  //////////////////////////////////////////////////
  // Beat counter and data-phase delay
  //////////////////////////////////////////////////

  // Count moves only on accepted beats so wait states hold the address
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wordCount <= '0;
    end else if (busInit) begin
      // Bus asked for a retry so start the line over
      wordCount <= '0;
    end else if (lineState && busAck) begin
      wordCount <= lastBeat ? '0 : wordCount + 1'b1;
    end
  end

  // Read data trails its address phase by one cycle
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wordCountDelayed <= '0;
      bufferCaptureEn  <= 1'b0;
    end else begin
      wordCountDelayed <= wordCount;
      bufferCaptureEn  <= busRead && busAck;
    end
  end

  //////////////////////////////////////////////////
  // Bus and CPU controls
  //////////////////////////////////////////////////

  // Address phase strobes follow the state only
  assign busRead  = (state == busPkg::stLineFetch) || (state == busPkg::stUncachedRead);
  assign busWrite = (state == busPkg::stLineWrite) || (state == busPkg::stUncachedWrite);

  always_comb begin
    hTrans = busPkg::idle;
    hBurst = busPkg::single;
    // First beat of any transfer is NONSEQ
    if (busRead || busWrite) begin
      hTrans = (lineState && (wordCount != '0)) ? busPkg::seq : busPkg::nonSeq;
    end
    if (lineState) begin
      hBurst = lineBurst;
    end
  end

  // One-cycle pulses on the closing acknowledge
  assign busTransComplete = busAck && (uncachedState || (lineState && lastBeat));
  assign cacheBusAck      = busAck && lineState && lastBeat;

  // Stall opens with the request, CPU hold keeps it up in done
  assign busStall = ((state == busPkg::stReady) && anyReq) || uncachedState || lineState ||
                    (doneState && cpuBusy);
  assign busCommitted = uncachedState || lineState;

  // LSU address stays selected through the done state
  assign selUncachedAdr = ((state == busPkg::stReady) && uncachedReq) || uncachedState ||
                          (state == busPkg::stUncachedReadDone) ||
                          (state == busPkg::stUncachedWriteDone);
  // LSU store word goes on the bus for uncached writes
  assign selLsuBusWord = ((state == busPkg::stReady) && uncachedWriteReq) ||
                         (state == busPkg::stUncachedWrite);

endmodule

`default_nettype wire

/* rtl/busPkg.sv */
// Bus-side enums shared by the controller and the testbench; only incrementing AHB bursts exist
`default_nettype none

package busPkg;

  //////////////////////////////////////////////////
  // Controller states
  //////////////////////////////////////////////////

  // Eight states fit in a 3-bit register
  typedef enum logic [2:0] {
    stReady,
    stUncachedRead,
    stUncachedReadDone,
    stUncachedWrite,
    stUncachedWriteDone,
    stLineFetch,
    stLineWrite,
    stLineDone
  } busStateE;

  //////////////////////////////////////////////////
  // Request and bus encodings
  //////////////////////////////////////////////////

  // Bit 1 of the LSU request reads and bit 0 writes
  // Atomics set both bits and are run as a read
  typedef enum logic [1:0] {
    rwNone  = 2'b00,
    rwWrite = 2'b01,
    rwRead  = 2'b10,
    rwAmo   = 2'b11
  } memRwE;

  // AHB transfer type without BUSY
  typedef enum logic [2-1:0] {
    idle   = 2'b00,
    nonSeq = 2'b10,
    seq    = 2'b11
  } hTransE;

  // AHB burst codes for single beats and fixed-length incrementing bursts
  typedef enum logic [2:0] {
    single = 3'b000,
    incr4  = 3'b011,
    incr8  = 3'b101,
    incr16 = 3'b111
  } hBurstE;

endpackage

`default_nettype wire

/* rtl/busTop.sv */
// Bus side of the cache unit; wordsPerLine is 4, 8 or 16 and xLen is 32 or 64
`timescale 1ns/10ps
`default_nettype none

module busTop #(
  parameter int xLen         = 64,
  parameter int paBits       = 32,
  parameter int wordsPerLine = 4,
  parameter int lineLen      = wordsPerLine * xLen,
  parameter int logWpl       = $clog2(wordsPerLine),
  parameter int cacheEnabled = 1
) (
  input  logic                clk,
  input  logic                arstN,
  //////////////////////////////////////////////////
  // Cache requester
  input  logic [paBits-1:0]   cacheBusAdr,
  input  logic                cacheFetchLine,
  input  logic                cacheWriteLine,
  output logic                cacheBusAck,
  output logic [lineLen-1:0]  lineData,
  //////////////////////////////////////////////////
  // Load/store unit
  input  logic [paBits-1:0]   lsuPAdr,
  input  busPkg::memRwE       lsuRw,
  input  logic [2:0]          lsuFunct3,
  input  logic                cacheable,
  input  logic                ignoreRequest,
  input  logic                cpuBusy,
  output logic                busStall,
  output logic                busCommitted,
  output logic                selUncachedAdr,
  output logic                selLsuBusWord,
  //////////////////////////////////////////////////
  // AHB-Lite style bus
  input  logic [xLen-1:0]     hrData,
  input  logic                busAck,
  input  logic                busInit,
  output logic [paBits-1:0]   hAddr,
  output logic [2:0]          hSize,
  output logic [2:0]          hBurst,
  output logic [1:0]          hTrans,
  output logic                busRead,
  output logic                busWrite,
  output logic                busTransComplete,
  output logic [logWpl-1:0]   wordCount
);

  // Line geometry and cache enable set here only
  busDp #(
    .xLen         (xLen),
    .paBits       (paBits),
    .wordsPerLine (wordsPerLine),
    .lineLen      (lineLen),
    .logWpl       (logWpl),
    .cacheEnabled (cacheEnabled)
  ) dp (
    .clk, .arstN,
    // Cache
    .cacheBusAdr, .cacheFetchLine, .cacheWriteLine, .cacheBusAck, .lineData,
    // LSU
    .lsuPAdr, .lsuRw, .lsuFunct3, .cacheable, .ignoreRequest, .cpuBusy,
    .busStall, .busCommitted, .selUncachedAdr, .selLsuBusWord,
    // Bus
    .hrData, .busAck, .busInit, .hAddr, .hSize, .hBurst, .hTrans,
    .busRead, .busWrite, .busTransComplete, .wordCount
  );

endmodule

`default_nettype wire

/* rtl/lineBuffer.sv */
// Line fill buffer; read data must be valid the cycle after its busAck, word lands the cycle after
`timescale 1ns/10ps
`default_nettype none

module lineBuffer #(
  parameter int xLen,
  parameter int wordsPerLine
) (
  input  logic                              clk,
  input  logic                              arstN,
  // Read data from the bus data phase
  input  logic [xLen-1:0]                   hrData,
  input  logic                              bufferCaptureEn,
  input  logic [$clog2(wordsPerLine)-1:0]   wordCountDelayed,
  // Whole line, word 0 in the low bits
  output logic [wordsPerLine*xLen-1:0]      lineData
);

  localparam int idxBits = $clog2(wordsPerLine);

  logic [wordsPerLine-1:0] captureWord;

  //////////////////////////////////////////////////
  // Capture decode
  //////////////////////////////////////////////////

  // One-hot enable from the delayed beat index
  always_comb begin
    for (int w = 0; w < wordsPerLine; w++) begin
      captureWord[w] = bufferCaptureEn && (wordCountDelayed == idxBits'(w));
    end
  end

  //////////////////////////////////////////////////
  // Word registers
  //////////////////////////////////////////////////

  // Unselected words keep their value
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      lineData <= '0;
    end else begin
      for (int w = 0; w < wordsPerLine; w++) begin
        if (captureWord[w]) begin
          lineData[w*xLen +: xLen] <= hrData;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and scans the log for a failure
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
  --top-module busTb \
  -f all.f \
  -o simBus

./obj_dir/simBus | tee sim.log

if grep -qF '** FAIL **' sim.log; then
  echo "Simulation reported errors"
  exit 1
fi

echo "Simulation finished without errors"
exit 0

/* verification/busTb.sv */
// Testbench at the default 64-bit, 4-word line; memory data is the address XOR a fixed pattern
`timescale 1ns/10ps
`default_nettype none

module busTb;

  localparam int xLen         = 64;
  localparam int paBits       = 32;
  localparam int wordsPerLine = 4;
  localparam int lineLen      = wordsPerLine * xLen;
  localparam int logWpl       = 2;
  localparam int numRows      = 10;
  // Worst row is a line with 3 wait states per beat plus request, hold and drain cycles
  localparam int cycleLimit   = numRows * (wordsPerLine * 4 + 10);

  // Row kinds
  localparam logic [2:0] kFetch  = 3'd0;
  localparam logic [2:0] kWrite  = 3'd1;
  localparam logic [2:0] kRead   = 3'd2;
  localparam logic [2:0] kStore  = 3'd3;
  localparam logic [2:0] kIgnore = 3'd4;

  // One row of stimulus with its expected beat count
  typedef struct packed {
    logic [2:0]        kind;
    logic [paBits-1:0] addr;
    logic [2:0]        funct3;
    logic              cacheable;
    logic [3:0]        hold;
    logic [4:0]        expBeats;
  } rowT;

  rowT rows [numRows];

  logic                clk            = 1'b0;
  logic                arstN          = 1'b0;
  logic [paBits-1:0]   cacheBusAdr    = '0;
  logic                cacheFetchLine = 1'b0;
  logic                cacheWriteLine = 1'b0;
  logic [paBits-1:0]   lsuPAdr        = '0;
  busPkg::memRwE       lsuRw          = busPkg::rwNone;
  logic [2:0]          lsuFunct3      = 3'd0;
  logic                cacheable      = 1'b0;
  logic                ignoreRequest  = 1'b0;
  logic                cpuBusy        = 1'b0;
  logic [xLen-1:0]     hrData         = '0;
  logic                busAck         = 1'b0;
  logic                busInit        = 1'b0;

  logic                cacheBusAck;
  logic [lineLen-1:0]  lineData;
  logic                busStall;
  logic                busCommitted;
  logic                selUncachedAdr;
  logic                selLsuBusWord;
  logic [paBits-1:0]   hAddr;
  logic [2:0]          hSize;
  logic [2:0]          hBurst;
  logic [1:0]          hTrans;
  logic                busRead;
  logic                busWrite;
  logic                busTransComplete;
  logic [logWpl-1:0]   wordCount;

  int                  checks     = 0;
  int                  errors     = 0;
  int                  cycleCount = 0;
  integer              seed       = 32'h0309_a283;
  int                  waitLeft   = 0;
  logic                waiting    = 1'b0;
  logic [paBits-1:0]   ackAddr    = '0;

  busTop #(
    .xLen         (xLen),
    .paBits       (paBits),
    .wordsPerLine (wordsPerLine),
    .cacheEnabled (1)
  ) uut (
    .clk, .arstN,
    .cacheBusAdr, .cacheFetchLine, .cacheWriteLine, .cacheBusAck, .lineData,
    .lsuPAdr, .lsuRw, .lsuFunct3, .cacheable, .ignoreRequest, .cpuBusy,
    .busStall, .busCommitted, .selUncachedAdr, .selLsuBusWord,
    .hrData, .busAck, .busInit, .hAddr, .hSize, .hBurst, .hTrans,
    .busRead, .busWrite, .busTransComplete, .wordCount
  );

  always #5 clk = ~clk;

  //////////////////////////////////////////////////
  // Memory model and run limit
  //////////////////////////////////////////////////

  // Memory contents as a function of the byte address
  function automatic logic [xLen-1:0] beatData(input logic [paBits-1:0] addr);
    beatData = {{(xLen - paBits){1'b0}}, addr} ^ 64'h5a5a_0000_a5a5_0000;
  endfunction

  // 0 to 3 wait cycles per beat, read data one cycle after the acknowledge
  always @(negedge clk) begin
    busAck <= 1'b0;
    if (busAck) begin
      hrData <= beatData(ackAddr);
    end
    if (arstN && (busRead || busWrite)) begin
      if (!waiting) begin
        waitLeft = $random(seed) & 3;
        waiting  = 1'b1;
      end
      if (waitLeft == 0) begin
        busAck  <= 1'b1;
        ackAddr <= hAddr;
        waiting  = 1'b0;
      end else begin
        waitLeft = waitLeft - 1;
      end
    end
  end

  always @(posedge clk) begin
    if (arstN) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= cycleLimit) begin
        $display("Timeout: the run did not finish within %0d cycles after reset", cycleLimit);
        $display("** FAIL **");
        $finish;
      end
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic checkValue(input string name, input logic [63:0] expected,
                            input logic [63:0] actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("Fail %s expected %0h actual %0h", name, expected, actual);
    end
  endtask

  // Kind, address, funct3, cacheable, cpuBusy hold, expected beats
  task automatic fillTable();
    rows[0] = '{kFetch,  32'h0000_1000, 3'd3, 1'b1, 4'd0, 5'd4};
    rows[1] = '{kFetch,  32'h0000_2a40, 3'd3, 1'b1, 4'd2, 5'd4};
    rows[2] = '{kRead,   32'h1000_0008, 3'd2, 1'b0, 4'd0, 5'd1};
    rows[3] = '{kStore,  32'h1000_0010, 3'd1, 1'b0, 4'd1, 5'd1};
    rows[4] = '{kWrite,  32'h0000_3fe0, 3'd3, 1'b1, 4'd0, 5'd4};
    rows[5] = '{kIgnore, 32'h1000_0020, 3'd3, 1'b0, 4'd0, 5'd0};
    // Cacheable LSU read is the cache's job, so the bus stays quiet
    rows[6] = '{kRead,   32'h2000_0004, 3'd2, 1'b1, 4'd0, 5'd0};
    rows[7] = '{kWrite,  32'h0000_0100, 3'd3, 1'b1, 4'd3, 5'd4};
    rows[8] = '{kRead,   32'h1000_0ffc, 3'd2, 1'b0, 4'd2, 5'd1};
    rows[9] = '{kFetch,  32'h8000_0fe0, 3'd3, 1'b1, 4'd1, 5'd4};
  endtask

  task automatic driveRequest(input rowT row);
    @(negedge clk);
    cacheable <= row.cacheable;
    cpuBusy   <= (row.hold != 4'd0);
    lsuFunct3 <= row.funct3;
    case (row.kind)
      kFetch: begin
        cacheBusAdr    <= row.addr;
        cacheFetchLine <= 1'b1;
      end
      kWrite: begin
        cacheBusAdr    <= row.addr;
        cacheWriteLine <= 1'b1;
      end
      kRead: begin
        lsuPAdr <= row.addr;
        lsuRw   <= busPkg::rwRead;
      end
      kStore: begin
        lsuPAdr <= row.addr;
        lsuRw   <= busPkg::rwWrite;
      end
      default: begin
        lsuPAdr       <= row.addr;
        lsuRw         <= busPkg::rwRead;
        ignoreRequest <= 1'b1;
      end
    endcase
  endtask

  // Drops the request levels but leaves cpuBusy alone
  task automatic clearRequest();
    cacheFetchLine <= 1'b0;
    cacheWriteLine <= 1'b0;
    lsuRw          <= busPkg::rwNone;
    ignoreRequest  <= 1'b0;
  endtask

  task automatic checkResetState();
    checkValue("reset busRead", 64'd0, 64'(busRead));
    checkValue("reset busWrite", 64'd0, 64'(busWrite));
    checkValue("reset busStall", 64'd0, 64'(busStall));
    checkValue("reset busCommitted", 64'd0, 64'(busCommitted));
    checkValue("reset busTransComplete", 64'd0, 64'(busTransComplete));
    checkValue("reset cacheBusAck", 64'd0, 64'(cacheBusAck));
    checkValue("reset hTrans", 64'(busPkg::idle), 64'(hTrans));
    checkValue("reset hBurst", 64'(busPkg::single), 64'(hBurst));
    checkValue("reset selUncachedAdr", 64'd0, 64'(selUncachedAdr));
    checkValue("reset selLsuBusWord", 64'd0, 64'(selLsuBusWord));
    checkValue("reset wordCount", 64'd0, 64'(wordCount));
    checkValue("reset lineData", 64'd0, 64'(|lineData));
  endtask

  //////////////////////////////////////////////////
  // One table row
  //////////////////////////////////////////////////

  task automatic runRow(input int r);
    rowT               row;
    string             tag;
    logic              isLine;
    logic              isWrite;
    logic              active;
    logic              prevWait;
    logic [paBits-1:0] prevAddr;
    logic [1:0]        prevTrans;
    logic [paBits-1:0] expAddr;
    int                beats;
    int                lineAcks;
    row       = rows[r];
    tag       = $sformatf("row%0d", r);
    isLine    = (row.kind == kFetch) || (row.kind == kWrite);
    isWrite   = (row.kind == kWrite) || (row.kind == kStore);
    active    = isLine || (((row.kind == kRead) || (row.kind == kStore)) && !row.cacheable);
    prevWait  = 1'b0;
    prevAddr  = '0;
    prevTrans = '0;
    beats     = 0;
    lineAcks  = 0;
    driveRequest(row);
    if (!active) begin
      // Nothing may reach the bus
      repeat (6) begin
        @(posedge clk);
        checkValue({tag, " idle hTrans"}, 64'(busPkg::idle), 64'(hTrans));
        checkValue({tag, " idle strobes"}, 64'd0, 64'(busRead | busWrite));
        checkValue({tag, " idle busStall"}, 64'd0, 64'(busStall));
      end
      @(negedge clk);
      clearRequest();
      cpuBusy <= 1'b0;
    end else begin
      // Request cycle in the ready state
      @(posedge clk);
      checkValue({tag, " request busStall"}, 64'd1, 64'(busStall));
      checkValue({tag, " request busCommitted"}, 64'd0, 64'(busCommitted));
      checkValue({tag, " request hTrans"}, 64'(busPkg::idle), 64'(hTrans));
      do begin
        @(posedge clk);
        if (busRead || busWrite) begin
          expAddr = isLine ? row.addr + paBits'(beats * (xLen / 8)) : row.addr;
          checkValue({tag, " hAddr"}, 64'(expAddr), 64'(hAddr));
          checkValue({tag, " hTrans"}, (beats == 0) ? 64'(busPkg::nonSeq) : 64'(busPkg::seq),
                     64'(hTrans));
          checkValue({tag, " hBurst"}, isLine ? 64'(busPkg::incr4) : 64'(busPkg::single),
                     64'(hBurst));
          checkValue({tag, " hSize"}, isLine ? 64'd3 : 64'(row.funct3), 64'(hSize));
          checkValue({tag, " busWrite"}, 64'(isWrite), 64'(busWrite));
          checkValue({tag, " busRead"}, 64'(!isWrite), 64'(busRead));
          checkValue({tag, " busStall"}, 64'd1, 64'(busStall));
          checkValue({tag, " busCommitted"}, 64'd1, 64'(busCommitted));
          checkValue({tag, " selUncachedAdr"}, 64'(!isLine), 64'(selUncachedAdr));
          checkValue({tag, " selLsuBusWord"}, 64'(isWrite && !isLine), 64'(selLsuBusWord));
          // Beat index of the address phase on the bus
          checkValue({tag, " wordCount"}, isLine ? 64'(beats) : 64'd0, 64'(wordCount));
          // Wait states must hold the address phase
          if (prevWait) begin
            checkValue({tag, " held hAddr"}, 64'(prevAddr), 64'(hAddr));
            checkValue({tag, " held hTrans"}, 64'(prevTrans), 64'(hTrans));
          end
          prevWait  = !busAck;
          prevAddr  = hAddr;
          prevTrans = hTrans;
          if (busAck) begin
            beats++;
          end
        end else begin
          errors++;
          $display("%s: the DUT dropped its address phase before the transfer ended", tag);
        end
        if (cacheBusAck) begin
          lineAcks++;
        end
      end while (!busTransComplete);
      checkValue({tag, " beats"}, 64'(row.expBeats), 64'(beats));
      checkValue({tag, " cacheBusAck pulses"}, isLine ? 64'd1 : 64'd0, 64'(lineAcks));
      @(negedge clk);
      clearRequest();
      // Done state holds the stall while the CPU is busy
      repeat (row.hold) begin
        @(posedge clk);
        checkValue({tag, " hold busStall"}, 64'd1, 64'(busStall));
        checkValue({tag, " hold busCommitted"}, 64'd0, 64'(busCommitted));
        checkValue({tag, " hold cacheBusAck"}, 64'd0, 64'(cacheBusAck));
        checkValue({tag, " hold busTransComplete"}, 64'd0, 64'(busTransComplete));
        @(negedge clk);
      end
      cpuBusy <= 1'b0;
      @(posedge clk);
      checkValue({tag, " release busStall"}, 64'd0, 64'(busStall));
      checkValue({tag, " release cacheBusAck"}, 64'd0, 64'(cacheBusAck));
      checkValue({tag, " release busTransComplete"}, 64'd0, 64'(busTransComplete));
      @(negedge clk);
      // Line buffer has taken the last beat by now
      if (row.kind == kFetch) begin
        for (int k = 0; k < wordsPerLine; k++) begin
          checkValue($sformatf("%s lineData word %0d", tag, k),
                     beatData(row.addr + paBits'(k * (xLen / 8))),
                     lineData[k*xLen +: xLen]);
        end
      end else if (row.kind == kRead) begin
        checkValue({tag, " lineData word 0"}, beatData(row.addr), lineData[xLen-1:0]);
      end
    end
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    fillTable();
    repeat (10) @(posedge clk);
    @(negedge clk);
    arstN <= 1'b1;
    @(posedge clk);
    checkResetState();
    for (int r = 0; r < numRows; r++) begin
      runRow(r);
    end
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
